/* source/serial_pkg.sv */
package serial_pkg;

    // frame and sampling geometry
    localparam int data_width      = 8;
    localparam int samples_per_bit = 4;
    localparam int div_width       = 16;

    // APB byte offsets
    localparam int addr_data   = 'h0;
    localparam int addr_status = 'h4;
    localparam int addr_div    = 'h8;

    // status register bit positions
    localparam int st_rx_valid  = 0;
    localparam int st_tx_busy   = 1;
    localparam int st_frame_err = 2;
    localparam int st_overrun   = 3;

    // one tick every four clocks out of reset
    localparam logic [div_width-1:0] div_reset = 16'd3;

endpackage

/* source/baud_tick_gen.sv */
`timescale 1ns/10ps

module baud_tick_gen (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [serial_pkg::div_width-1:0] div,
    output logic                             tick
);

    logic [serial_pkg::div_width-1:0] cnt;

    // the divisor is only sampled on reload, so a new value waits for the wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= div;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

/* source/rx_majority_sampler.sv */
`timescale 1ns/10ps

module rx_majority_sampler (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    input  logic rxd,
    input  logic frame_end,
    output logic bit_valid,
    output logic bit_value
);

    // phase states carry their own phase number
    localparam logic [2:0] s_ph0  = 3'd0;
    localparam logic [2:0] s_ph1  = 3'd1;
    localparam logic [2:0] s_ph2  = 3'd2;
    localparam logic [2:0] s_ph3  = 3'(serial_pkg::samples_per_bit - 1);
    localparam logic [2:0] s_hunt = 3'd4;
    localparam logic [2:0] s_wait = 3'd5;

    logic [2:0] state;
    logic [2:0] samples;
    logic       vote;

    assign vote = (samples[0] & samples[1]) |
                  (samples[0] & samples[2]) |
                  (samples[1] & samples[2]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= s_hunt;
            samples   <= 3'b000;
            bit_valid <= 1'b0;
            bit_value <= 1'b0;
        end else begin
            bit_valid <= 1'b0;
            if (frame_end) begin
                state <= s_hunt;
            end else begin
                case (state)
                    s_hunt: if (tick && rxd) state <= s_wait;
                    s_wait: begin
                        // the tick that sees the start edge counts as phase 0
                        if (tick && !rxd) begin
                            samples <= {2'b00, rxd};
                            state   <= s_ph1;
                        end
                    end
                    s_ph0: begin
                        if (tick) begin
                            samples[0] <= rxd;
                            state      <= s_ph1;
                        end
                    end
                    s_ph1: begin
                        if (tick) begin
                            samples[1] <= rxd;
                            state      <= s_ph2;
                        end
                    end
                    s_ph2: begin
                        if (tick) begin
                            samples[2] <= rxd;
                            state      <= s_ph3;
                        end
                    end
                    s_ph3: begin
                        // stay here for the clock that carries bit_valid
                        if (bit_valid) begin
                            samples <= 3'b000;
                            state   <= s_ph0;
                        end else if (tick) begin
                            bit_valid <= 1'b1;
                            bit_value <= vote;
                        end
                    end
                    default: state <= s_hunt;
                endcase
            end
        end
    end

    a_valid_in_ph3: assert property (@(posedge clk) disable iff (rst)
        bit_valid |-> state == s_ph3);

endmodule

/* source/rx_deframer.sv */
`timescale 1ns/10ps

module rx_deframer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              bit_valid,
    input  logic                              bit_value,
    output logic                              byte_valid,
    output logic [serial_pkg::data_width-1:0] byte_data,
    output logic                              frame_err,
    output logic                              frame_end
);

    localparam int cnt_width = $clog2(serial_pkg::data_width + 2);
    localparam logic [cnt_width-1:0] stop_idx = cnt_width'(serial_pkg::data_width + 1);

    logic [cnt_width-1:0]              bit_cnt;
    logic                              start_bad;
    logic [serial_pkg::data_width-1:0] shreg;
    logic                              data_bit;

    // bits 1 to data_width carry the payload
    assign data_bit = bit_valid && (bit_cnt != '0) && (bit_cnt != stop_idx);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt    <= '0;
            start_bad  <= 1'b0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
            frame_end  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
            frame_end  <= 1'b0;
            if (bit_valid) begin
                if (bit_cnt == '0) begin
                    start_bad <= bit_value;
                    bit_cnt   <= bit_cnt + 1'b1;
                end else if (bit_cnt == stop_idx) begin
                    byte_valid <= !start_bad && bit_value;
                    frame_err  <= start_bad || !bit_value;
                    frame_end  <= 1'b1;
                    bit_cnt    <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (data_bit) begin
            shreg <= {bit_value, shreg[serial_pkg::data_width-1:1]};
        end
    end

    assign byte_data = shreg;

    a_byte_or_err: assert property (@(posedge clk) disable iff (rst)
        !(byte_valid && frame_err));

endmodule

/* source/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              tick,
    input  logic                              tx_start,
    input  logic [serial_pkg::data_width-1:0] tx_data,
    output logic                              txd,
    output logic                              tx_busy
);

    localparam int frame_len  = serial_pkg::data_width + 2;
    localparam int bcnt_width = $clog2(frame_len);
    localparam int tcnt_width = $clog2(serial_pkg::samples_per_bit);
    localparam logic [bcnt_width-1:0] last_bit  = bcnt_width'(frame_len - 1);
    localparam logic [tcnt_width-1:0] last_tick = tcnt_width'(serial_pkg::samples_per_bit - 1);

    logic [frame_len-1:0]  frame;
    logic [bcnt_width-1:0] bit_cnt;
    logic [bcnt_width-1:0] next_bit;
    logic [tcnt_width-1:0] tick_cnt;
    logic                  on_line;

    assign next_bit = bit_cnt + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            txd      <= 1'b1;
            tx_busy  <= 1'b0;
            on_line  <= 1'b0;
            bit_cnt  <= '0;
            tick_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy  <= 1'b1;
                bit_cnt  <= '0;
                tick_cnt <= '0;
            end
        end else if (tick) begin
            // the first tick after the start request drives the start bit
            if (!on_line) begin
                txd     <= frame[0];
                on_line <= 1'b1;
            end else if (tick_cnt == last_tick) begin
                tick_cnt <= '0;
                if (bit_cnt == last_bit) begin
                    txd     <= 1'b1;
                    tx_busy <= 1'b0;
                    on_line <= 1'b0;
                end else begin
                    txd     <= frame[next_bit];
                    bit_cnt <= next_bit;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start && !tx_busy) begin
            frame <= {1'b1, tx_data, 1'b0};
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> txd);

endmodule

/* source/serial_apb_regs.sv */
`timescale 1ns/10ps

module serial_apb_regs #(
    parameter int addr_width = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [addr_width-1:0]             paddr,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  logic                              byte_valid,
    input  logic [serial_pkg::data_width-1:0] byte_data,
    input  logic                              frame_err,
    input  logic                              tx_busy,
    output logic                              tx_start,
    output logic [serial_pkg::data_width-1:0] tx_data,
    output logic [serial_pkg::div_width-1:0]  div
);

    logic                              access;
    logic                              sel_data;
    logic                              sel_status;
    logic                              sel_div;
    logic                              rd_data;
    logic                              rd_status;
    logic [serial_pkg::data_width-1:0] rx_byte;
    logic                              rx_valid;
    logic                              err_flag;
    logic                              overrun;

    assign access     = psel && penable;
    assign sel_data   = paddr == addr_width'(serial_pkg::addr_data);
    assign sel_status = paddr == addr_width'(serial_pkg::addr_status);
    assign sel_div    = paddr == addr_width'(serial_pkg::addr_div);
    assign rd_data    = access && !pwrite && sel_data;
    assign rd_status  = access && !pwrite && sel_status;

    // a data write while the transmitter is busy is refused and dropped
    assign pready   = 1'b1;
    assign pslverr  = access && pwrite && sel_data && tx_busy;
    assign tx_start = access && pwrite && sel_data && !tx_busy;
    assign tx_data  = pwdata[serial_pkg::data_width-1:0];

    always_comb begin
        prdata = '0;
        if (rd_data) begin
            prdata[serial_pkg::data_width-1:0] = rx_byte;
        end else if (rd_status) begin
            prdata[serial_pkg::st_rx_valid]  = rx_valid;
            prdata[serial_pkg::st_tx_busy]   = tx_busy;
            prdata[serial_pkg::st_frame_err] = err_flag;
            prdata[serial_pkg::st_overrun]   = overrun;
        end else if (access && !pwrite && sel_div) begin
            prdata[serial_pkg::div_width-1:0] = div;
        end
    end

    // a new event wins over a read-clear in the same clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_valid <= 1'b0;
            err_flag <= 1'b0;
            overrun  <= 1'b0;
            div      <= serial_pkg::div_reset;
        end else begin
            if (byte_valid) begin
                rx_valid <= 1'b1;
            end else if (rd_data) begin
                rx_valid <= 1'b0;
            end
            if (frame_err) begin
                err_flag <= 1'b1;
            end else if (rd_status) begin
                err_flag <= 1'b0;
            end
            if (byte_valid && rx_valid && !rd_data) begin
                overrun <= 1'b1;
            end else if (rd_status) begin
                overrun <= 1'b0;
            end
            if (access && pwrite && sel_div) begin
                div <= pwdata[serial_pkg::div_width-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            rx_byte <= byte_data;
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

/* source/serial_link_top.sv */
`timescale 1ns/10ps

module serial_link_top #(
    parameter int addr_width = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [addr_width-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  rxd,
    output logic                  txd
);

    logic                              tick;
    logic [serial_pkg::div_width-1:0]  div;
    logic                              bit_valid;
    logic                              bit_value;
    logic                              frame_end;
    logic                              byte_valid;
    logic [serial_pkg::data_width-1:0] byte_data;
    logic                              frame_err;
    logic                              tx_start;
    logic [serial_pkg::data_width-1:0] tx_data;
    logic                              tx_busy;

    // one tick drives both directions
    baud_tick_gen baud_tick_gen_i (
        .clk  (clk),
        .rst  (rst),
        .div  (div),
        .tick (tick)
    );

    rx_majority_sampler rx_majority_sampler_i (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .rxd       (rxd),
        .frame_end (frame_end),
        .bit_valid (bit_valid),
        .bit_value (bit_value)
    );

    rx_deframer rx_deframer_i (
        .clk        (clk),
        .rst        (rst),
        .bit_valid  (bit_valid),
        .bit_value  (bit_value),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .frame_err  (frame_err),
        .frame_end  (frame_end)
    );

    uart_tx uart_tx_i (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

    serial_apb_regs #(
        .addr_width (addr_width)
    ) serial_apb_regs_i (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .frame_err  (frame_err),
        .tx_busy    (tx_busy),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .div        (div)
    );

endmodule

/* test/serial_link_tb.sv */
`timescale 1ns/10ps

module serial_link_tb;

    localparam int addr_width     = 4;
    localparam int clk_period     = 100;
    localparam int fast_div       = 3;
    localparam int slow_div       = 7;
    localparam int frame_overhead = 40;
    localparam int fast_frame     = 10 * serial_pkg::samples_per_bit * (fast_div + 1);
    localparam int slow_frame     = 10 * serial_pkg::samples_per_bit * (slow_div + 1);
    // 15 frames run at the reset divisor and 2 at the slow one, doubled for margin
    localparam int max_cycles = 2 * (15 * (fast_frame + frame_overhead) +
                                     2 * (slow_frame + frame_overhead));
    localparam logic [31:0] rx_mask  = 32'(1) << serial_pkg::st_rx_valid;
    localparam logic [31:0] err_mask = 32'(1) << serial_pkg::st_frame_err;
    localparam logic [31:0] ovr_mask = 32'(1) << serial_pkg::st_overrun;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [addr_width-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  rxd;
    logic                  txd;
    logic                  rxd_drv;
    logic                  loopback;

    int          cycles;
    int          n_checks;
    int          n_errors;
    int          test_start_errors;
    int          cur_div;
    logic [31:0] lfsr;
    string       test_name;

    assign rxd = loopback ? txd : rxd_drv;

    serial_link_top #(
        .addr_width (addr_width)
    ) serial_link_top_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .rxd     (rxd),
        .txd     (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("Error in %s (%s): expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = n_errors;
    endtask

    task automatic report_test();
        if (n_errors == test_start_errors) begin
            $display("%s: pass", test_name);
        end else begin
            $display("%s: %0d errors", test_name, n_errors - test_start_errors);
        end
    endtask

    task automatic apb_write(input int addr, input logic [31:0] data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr_width'(addr);
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(clk_period / 4);
        err = pslverr;
        check("pready", 1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input int addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr_width'(addr);
        @(negedge clk);
        penable = 1'b1;
        #(clk_period / 4);
        data = prdata;
        check("pready", 1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // the read that sees a flag also clears the read-clear flags
    task automatic wait_status(input logic [31:0] mask, output logic [31:0] s);
        do begin
            apb_read(serial_pkg::addr_status, s);
        end while ((s & mask) == 0);
    endtask

    // bits go out LSB first and a glitch pulls the line low for one clock near mid-bit
    // the glitch slides by one clock from bit to bit, so it lands on a sample tick
    // in some bit whatever the tick alignment
    task automatic drive_serial(input logic [9:0] bits, input logic [9:0] glitch);
        int bit_clocks;
        int tick_clocks;
        int glitch_at;
        tick_clocks = cur_div + 1;
        bit_clocks  = serial_pkg::samples_per_bit * tick_clocks;
        for (int i = 0; i < 10; i++) begin
            glitch_at = bit_clocks / 2 - tick_clocks / 2 + i % tick_clocks;
            for (int c = 0; c < bit_clocks; c++) begin
                @(negedge clk);
                if (glitch[i] && c == glitch_at) begin
                    rxd_drv = 1'b0;
                end else begin
                    rxd_drv = bits[i];
                end
            end
        end
        @(negedge clk);
        rxd_drv = 1'b1;
    endtask

    task automatic loopback_bytes(input int n);
        logic [7:0]  b;
        logic [31:0] s;
        logic        err;
        for (int k = 0; k < n; k++) begin
            rand_byte(b);
            apb_write(serial_pkg::addr_data, {24'h0, b}, err);
            check("write error", 0, err);
            wait_status(rx_mask | err_mask, s);
            check("rx_valid", 1, s[serial_pkg::st_rx_valid]);
            check("frame_err", 0, s[serial_pkg::st_frame_err]);
            apb_read(serial_pkg::addr_data, s);
            check("data", {24'h0, b}, s);
            apb_read(serial_pkg::addr_status, s);
            check("rx_valid after read", 0, s[serial_pkg::st_rx_valid]);
        end
    endtask

    task automatic reset_values();
        logic [31:0] s;
        start_test("reset");
        apb_read(serial_pkg::addr_status, s);
        check("status", 0, s);
        apb_read(serial_pkg::addr_div, s);
        check("div", 32'(serial_pkg::div_reset), s);
        check("txd", 1, txd);
        report_test();
    endtask

    task automatic loopback_random();
        start_test("loopback");
        loopback = 1'b1;
        loopback_bytes(8);
        report_test();
    endtask

    task automatic slow_divisor_loopback();
        logic [31:0] s;
        logic        err;
        start_test("slow_divisor");
        apb_write(serial_pkg::addr_div, slow_div, err);
        cur_div = slow_div;
        apb_read(serial_pkg::addr_div, s);
        check("div", slow_div, s);
        loopback_bytes(2);
        apb_write(serial_pkg::addr_div, 32'(serial_pkg::div_reset), err);
        cur_div = serial_pkg::div_reset;
        report_test();
    endtask

    task automatic glitch_rejection();
        logic [7:0]  b;
        logic [31:0] s;
        start_test("noise");
        loopback = 1'b0;
        for (int k = 0; k < 3; k++) begin
            if (k == 0) begin
                b = 8'hff;
            end else begin
                rand_byte(b);
            end
            drive_serial({1'b1, b, 1'b0}, {1'b0, b, 1'b0});
            wait_status(rx_mask | err_mask, s);
            check("status", rx_mask, s);
            apb_read(serial_pkg::addr_data, s);
            check("data", {24'h0, b}, s);
        end
        report_test();
    endtask

    task automatic stop_bit_error();
        logic [7:0]  b;
        logic [31:0] s;
        start_test("frame_error");
        rand_byte(b);
        drive_serial({1'b0, b, 1'b0}, 10'h0);
        wait_status(rx_mask | err_mask, s);
        check("status", err_mask, s);
        apb_read(serial_pkg::addr_status, s);
        check("status after clear", 0, s);
        report_test();
    endtask

    task automatic overrun_and_busy();
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [31:0] s;
        logic        err;
        start_test("errors");
        rand_byte(b1);
        rand_byte(b2);
        drive_serial({1'b1, b1, 1'b0}, 10'h0);
        wait_status(rx_mask | err_mask, s);
        check("first frame status", rx_mask, s);
        drive_serial({1'b1, b2, 1'b0}, 10'h0);
        wait_status(ovr_mask | err_mask, s);
        check("overrun status", rx_mask | ovr_mask, s);
        apb_read(serial_pkg::addr_data, s);
        check("data after overrun", {24'h0, b2}, s);
        // the second write lands while the first frame is still going out
        loopback = 1'b1;
        rand_byte(b1);
        rand_byte(b2);
        apb_write(serial_pkg::addr_data, {24'h0, b1}, err);
        check("first write error", 0, err);
        apb_read(serial_pkg::addr_status, s);
        check("tx_busy", 1, s[serial_pkg::st_tx_busy]);
        apb_write(serial_pkg::addr_data, {24'h0, b2}, err);
        check("busy write error", 1, err);
        wait_status(rx_mask | err_mask, s);
        check("rx_valid", 1, s[serial_pkg::st_rx_valid]);
        apb_read(serial_pkg::addr_data, s);
        check("data after busy write", {24'h0, b1}, s);
        report_test();
    endtask

    initial begin
        lfsr     = 32'hd0b414cc;
        cur_div  = serial_pkg::div_reset;
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        rxd_drv  = 1'b1;
        loopback = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        reset_values();
        loopback_random();
        slow_divisor_loopback();
        glitch_rejection();
        stop_bit_error();
        overrun_and_busy();
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* serial_link_top.f */
source/serial_pkg.sv
source/baud_tick_gen.sv
source/rx_majority_sampler.sv
source/rx_deframer.sv
source/uart_tx.sv
source/serial_apb_regs.sv
source/serial_link_top.sv
test/serial_link_tb.sv

/* Bender.yml */
package:
  name: serial_link

sources:
  - source/serial_pkg.sv
  - source/baud_tick_gen.sv
  - source/rx_majority_sampler.sv
  - source/rx_deframer.sv
  - source/uart_tx.sv
  - source/serial_apb_regs.sv
  - source/serial_link_top.sv
  - target: test
    files:
      - test/serial_link_tb.sv
